//--- soc_pkg.sv
`default_nettype none

package soc_pkg;

	// Bus widths
	localparam int DATA_W = 32;
	localparam int STRB_W = 4;

	// Pad and interrupt widths
	localparam int GPIO_W = 16;
	localparam int IRQ_W = 32;

	// I/O page lives at 0x0300_00xx
	localparam int IO_OFS_W = 8;
	localparam logic [DATA_W-IO_OFS_W-1:0] IO_PAGE = 24'h030000;

	// Byte offsets inside the I/O page
	typedef enum logic [IO_OFS_W-1:0] {
		GPIO_DATA = 8'h00,
		GPIO_OEB = 8'h04,
		GPIO_PU = 8'h08,
		GPIO_PD = 8'h0c,
		COMP_DEST = 8'h6c,
		RCOSC_DEST = 8'h74,
		XTAL_DEST = 8'ha0,
		TRAP_DEST = 8'ha8,
		IRQ7_SRC = 8'hb0,
		IRQ8_SRC = 8'hb4,
		// Read-only alarm status
		OVERTEMP_STAT = 8'he4,
		OVERTEMP_DEST = 8'he8
	} io_reg_e;

	// Shared encoding for every destination and source selector
	typedef enum logic [1:0] {
		ROUTE_NONE = 2'd0,
		ROUTE_A = 2'd1,
		ROUTE_B = 2'd2,
		ROUTE_C = 2'd3
	} route_e;

endpackage

`default_nettype wire

//--- bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module bus_decoder import soc_pkg::*; #(
	parameter int MEM_WORDS = 1024
) (
	input wire clk,
	input wire resetn,
	// Master request
	input wire mem_valid,
	input wire [DATA_W-1:0] mem_addr,
	input wire [DATA_W-1:0] mem_wdata,
	input wire [STRB_W-1:0] mem_wstrb,
	// Master response
	output logic mem_ready,
	output logic [DATA_W-1:0] mem_rdata,
	// External SRAM pins
	output logic ram_wenb,
	output logic [$clog2(MEM_WORDS)-1:0] ram_addr,
	output logic [DATA_W-1:0] ram_wdata,
	input wire [DATA_W-1:0] ram_rdata,
	// Register block request and read data
	output logic io_req,
	output logic [IO_OFS_W-1:0] io_ofs,
	output logic [DATA_W-1:0] io_wdata,
	output logic [STRB_W-1:0] io_wstrb,
	input wire [DATA_W-1:0] io_rdata
);
	localparam int RAM_AW = $clog2(MEM_WORDS);
	// Scratchpad window size in bytes
	localparam logic [DATA_W-1:0] RAM_BYTES = DATA_W'(4 * MEM_WORDS);

	// Which peer answers the access in flight
	typedef enum logic [1:0] {
		TGT_NONE,
		TGT_RAM,
		TGT_IO
	} tgt_e;

	logic start;
	logic ram_hit;
	logic io_hit;
	logic is_write;
	tgt_e tgt_d;
	tgt_e tgt_q;

	// First cycle of an access, no ack pending
	assign start = mem_valid && !mem_ready;
	assign ram_hit = mem_addr < RAM_BYTES;
	// Upper 24 bits pick the I/O page
	assign io_hit = mem_addr[DATA_W-1:IO_OFS_W] == IO_PAGE;
	// Any strobe set means write
	assign is_write = |mem_wstrb;

	// SRAM window wins if the two ever overlap
	always_comb begin
		if (ram_hit) begin
			tgt_d = TGT_RAM;
		end else if (io_hit) begin
			tgt_d = TGT_IO;
		end else begin
			tgt_d = TGT_NONE;
		end
	end

	// Write enable only in the request cycle
	assign ram_wenb = !(start && ram_hit && is_write);
	// Word address, byte lanes dropped
	assign ram_addr = mem_addr[RAM_AW+1:2];
	// Strobes not honored by the SRAM macro
	assign ram_wdata = mem_wdata;

	// One-cycle strobe toward the register block
	assign io_req = start && tgt_d == TGT_IO;
	assign io_ofs = mem_addr[IO_OFS_W-1:0];
	assign io_wdata = mem_wdata;
	assign io_wstrb = mem_wstrb;

	// Registered ack covers every target, unmapped included
	always_ff @(posedge clk) begin
		if (!resetn) begin
			mem_ready <= 1'b0;
			tgt_q <= TGT_NONE;
		end else begin
			mem_ready <= start;
			if (start) begin
				tgt_q <= tgt_d;
			end
		end
	end

	// Response mux in the ack cycle
	always_comb begin
		mem_rdata = '0;
		if (mem_ready) begin
			case (tgt_q)
				TGT_RAM: mem_rdata = ram_rdata;
				TGT_IO: mem_rdata = io_rdata;
				// Unmapped reads return zero
				default: mem_rdata = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- io_regs.sv
`timescale 1ns/1ps
`default_nettype none

module io_regs import soc_pkg::*; (
	input wire clk,
	input wire resetn,
	// Request from the decoder
	input wire io_req,
	input wire [IO_OFS_W-1:0] io_ofs,
	input wire [DATA_W-1:0] io_wdata,
	input wire [STRB_W-1:0] io_wstrb,
	output logic [DATA_W-1:0] io_rdata,
	// Pad state read back
	input wire [GPIO_W-1:0] gpio_in,
	input wire [GPIO_W-1:0] gpio_out,
	input wire overtemp,
	// GPIO control registers
	output logic [GPIO_W-1:0] gpio_reg,
	output logic [GPIO_W-1:0] gpio_oeb_reg,
	output logic [GPIO_W-1:0] gpio_pu_reg,
	output logic [GPIO_W-1:0] gpio_pd_reg,
	// Signal routing selectors
	output route_e comp_dest,
	output route_e rcosc_dest,
	output route_e xtal_dest,
	output route_e trap_dest,
	output route_e overtemp_dest,
	output route_e irq7_src,
	output route_e irq8_src
);
	io_reg_e ofs;

	assign ofs = io_reg_e'(io_ofs);

	// 16-bit register, low byte on strobe 0, high byte on strobe 1
	function automatic logic [GPIO_W-1:0] merge_half(
		input logic [GPIO_W-1:0] cur,
		input logic [DATA_W-1:0] wdata,
		input logic [STRB_W-1:0] strb
	);
		logic [GPIO_W-1:0] res;
		res = cur;
		if (strb[0]) begin
			res[7:0] = wdata[7:0];
		end
		if (strb[1]) begin
			res[GPIO_W-1:8] = wdata[GPIO_W-1:8];
		end
		return res;
	endfunction

	// Selectors take bits 1:0 on strobe 0
	function automatic route_e sel_write(
		input route_e cur,
		input logic [DATA_W-1:0] wdata,
		input logic [STRB_W-1:0] strb
	);
		return strb[0] ? route_e'(wdata[1:0]) : cur;
	endfunction

	// Zero-extended read views
	function automatic logic [DATA_W-1:0] rd_half(input logic [GPIO_W-1:0] r);
		return {{(DATA_W-GPIO_W){1'b0}}, r};
	endfunction

	function automatic logic [DATA_W-1:0] rd_sel(input route_e s);
		return {{(DATA_W-2){1'b0}}, s};
	endfunction

	// Register writes land at the request edge
	always_ff @(posedge clk) begin
		if (!resetn) begin
			gpio_reg <= '0;
			// Outputs disabled out of reset
			gpio_oeb_reg <= '1;
			gpio_pu_reg <= '0;
			gpio_pd_reg <= '0;
			comp_dest <= ROUTE_NONE;
			rcosc_dest <= ROUTE_NONE;
			xtal_dest <= ROUTE_NONE;
			trap_dest <= ROUTE_NONE;
			overtemp_dest <= ROUTE_NONE;
			irq7_src <= ROUTE_NONE;
			irq8_src <= ROUTE_NONE;
		end else if (io_req) begin
			case (ofs)
				GPIO_DATA: gpio_reg <= merge_half(gpio_reg, io_wdata, io_wstrb);
				GPIO_OEB: gpio_oeb_reg <= merge_half(gpio_oeb_reg, io_wdata, io_wstrb);
				GPIO_PU: gpio_pu_reg <= merge_half(gpio_pu_reg, io_wdata, io_wstrb);
				GPIO_PD: gpio_pd_reg <= merge_half(gpio_pd_reg, io_wdata, io_wstrb);
				COMP_DEST: comp_dest <= sel_write(comp_dest, io_wdata, io_wstrb);
				RCOSC_DEST: rcosc_dest <= sel_write(rcosc_dest, io_wdata, io_wstrb);
				XTAL_DEST: xtal_dest <= sel_write(xtal_dest, io_wdata, io_wstrb);
				TRAP_DEST: trap_dest <= sel_write(trap_dest, io_wdata, io_wstrb);
				IRQ7_SRC: irq7_src <= sel_write(irq7_src, io_wdata, io_wstrb);
				IRQ8_SRC: irq8_src <= sel_write(irq8_src, io_wdata, io_wstrb);
				OVERTEMP_DEST: overtemp_dest <= sel_write(overtemp_dest, io_wdata, io_wstrb);
				// Status and unassigned offsets ignore writes
				default: ;
			endcase
		end
	end

	// Read word ready in the ack cycle
	always_ff @(posedge clk) begin
		if (io_req) begin
			case (ofs)
				// Pad output on top, pad input below
				GPIO_DATA: io_rdata <= {gpio_out, gpio_in};
				GPIO_OEB: io_rdata <= rd_half(gpio_oeb_reg);
				GPIO_PU: io_rdata <= rd_half(gpio_pu_reg);
				GPIO_PD: io_rdata <= rd_half(gpio_pd_reg);
				COMP_DEST: io_rdata <= rd_sel(comp_dest);
				RCOSC_DEST: io_rdata <= rd_sel(rcosc_dest);
				XTAL_DEST: io_rdata <= rd_sel(xtal_dest);
				TRAP_DEST: io_rdata <= rd_sel(trap_dest);
				IRQ7_SRC: io_rdata <= rd_sel(irq7_src);
				IRQ8_SRC: io_rdata <= rd_sel(irq8_src);
				OVERTEMP_STAT: io_rdata <= {{(DATA_W-1){1'b0}}, overtemp};
				OVERTEMP_DEST: io_rdata <= rd_sel(overtemp_dest);
				default: io_rdata <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- pin_router.sv
`timescale 1ns/1ps
`default_nettype none

module pin_router import soc_pkg::*; (
	// Register values
	input wire [GPIO_W-1:0] gpio_reg,
	input wire [GPIO_W-1:0] gpio_oeb_reg,
	input wire [GPIO_W-1:0] gpio_pu_reg,
	input wire [GPIO_W-1:0] gpio_pd_reg,
	// Destination selectors
	input wire route_e comp_dest,
	input wire route_e rcosc_dest,
	input wire route_e xtal_dest,
	input wire route_e trap_dest,
	input wire route_e overtemp_dest,
	// Signals that can be routed to pads
	input wire comp_in,
	input wire rcosc_in,
	input wire xtal_in,
	input wire trap_in,
	input wire overtemp,
	// Pad controls
	output logic [GPIO_W-1:0] gpio_out,
	output logic [GPIO_W-1:0] gpio_outenb,
	output logic [GPIO_W-1:0] gpio_pullup,
	output logic [GPIO_W-1:0] gpio_pulldown
);
	logic [GPIO_W-1:0] route_mask;
	logic [GPIO_W-1:0] route_val;
	logic [GPIO_W-1:0] grp_mask;

	// One-hot pin within a group, A is the lowest pin
	function automatic logic [2:0] pin_sel(input route_e s);
		case (s)
			ROUTE_A: return 3'b001;
			ROUTE_B: return 3'b010;
			ROUTE_C: return 3'b100;
			default: return 3'b000;
		endcase
	endfunction

	// Pins that carry a routed signal
	// Groups: ot 15:14, trap 13:11, free 10:8, xtal 7:5, rcosc 4:2, comp 1:0
	assign route_mask = {2'(pin_sel(overtemp_dest)), pin_sel(trap_dest), 3'b000,
		pin_sel(xtal_dest), pin_sel(rcosc_dest), 2'(pin_sel(comp_dest))};

	// Each group sees only its own signal
	assign route_val = {{2{overtemp}}, {3{trap_in}}, 3'b000,
		{3{xtal_in}}, {3{rcosc_in}}, {2{comp_in}}};

	// Whole group claimed while its selector is active
	assign grp_mask = {{2{overtemp_dest != ROUTE_NONE}}, {3{trap_dest != ROUTE_NONE}}, 3'b000,
		{3{xtal_dest != ROUTE_NONE}}, {3{rcosc_dest != ROUTE_NONE}},
		{2{comp_dest != ROUTE_NONE}}};

	// Routed signal replaces the data bit
	assign gpio_out = (gpio_reg & ~route_mask) | (route_val & route_mask);
	// Claimed pins are driven with no pulls
	assign gpio_outenb = gpio_oeb_reg & ~grp_mask;
	assign gpio_pullup = gpio_pu_reg & ~grp_mask;
	assign gpio_pulldown = gpio_pd_reg & ~grp_mask;

endmodule

`default_nettype wire

//--- irq_router.sv
`timescale 1ns/1ps
`default_nettype none

module irq_router import soc_pkg::*; (
	input wire [GPIO_W-1:0] gpio_in,
	// Source and destination selectors
	input wire route_e irq7_src,
	input wire route_e irq8_src,
	input wire route_e comp_dest,
	input wire route_e overtemp_dest,
	// Direct interrupt sources
	input wire comp_in,
	input wire overtemp,
	input wire irq_pin,
	input wire irq_spi,
	output logic [IRQ_W-1:0] irq
);
	// One of three pins, nothing for NONE
	function automatic logic pick3(input route_e s, input logic [2:0] pins);
		case (s)
			ROUTE_A: return pins[0];
			ROUTE_B: return pins[1];
			ROUTE_C: return pins[2];
			default: return 1'b0;
		endcase
	endfunction

	always_comb begin
		irq = '0;
		irq[5] = irq_pin;
		irq[6] = irq_spi;
		// GPIO 0..2 and 3..5
		irq[7] = pick3(irq7_src, gpio_in[2:0]);
		irq[8] = pick3(irq8_src, gpio_in[5:3]);
		// Route C sends comparator and alarm to the CPU
		irq[9] = comp_in && comp_dest == ROUTE_C;
		irq[10] = overtemp && overtemp_dest == ROUTE_C;
	end

endmodule

`default_nettype wire

//--- soc_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_bus_top import soc_pkg::*; #(
	parameter int MEM_WORDS = 1024
) (
	input wire clk,
	input wire resetn,
	// Master bus
	input wire mem_valid,
	input wire [DATA_W-1:0] mem_addr,
	input wire [DATA_W-1:0] mem_wdata,
	input wire [STRB_W-1:0] mem_wstrb,
	output logic mem_ready,
	output logic [DATA_W-1:0] mem_rdata,
	// External SRAM
	output logic ram_wenb,
	output logic [$clog2(MEM_WORDS)-1:0] ram_addr,
	output logic [DATA_W-1:0] ram_wdata,
	input wire [DATA_W-1:0] ram_rdata,
	// Pads
	input wire [GPIO_W-1:0] gpio_in,
	output logic [GPIO_W-1:0] gpio_out,
	output logic [GPIO_W-1:0] gpio_outenb,
	output logic [GPIO_W-1:0] gpio_pullup,
	output logic [GPIO_W-1:0] gpio_pulldown,
	// Analog and core sideband
	input wire comp_in,
	input wire rcosc_in,
	input wire xtal_in,
	input wire trap_in,
	input wire overtemp,
	// Interrupts
	input wire irq_pin,
	input wire irq_spi,
	output logic [IRQ_W-1:0] irq
);
	// Decoder to register block
	logic io_req;
	logic [IO_OFS_W-1:0] io_ofs;
	logic [DATA_W-1:0] io_wdata;
	logic [STRB_W-1:0] io_wstrb;
	logic [DATA_W-1:0] io_rdata;

	// Register block to routers
	logic [GPIO_W-1:0] gpio_reg;
	logic [GPIO_W-1:0] gpio_oeb_reg;
	logic [GPIO_W-1:0] gpio_pu_reg;
	logic [GPIO_W-1:0] gpio_pd_reg;
	route_e comp_dest;
	route_e rcosc_dest;
	route_e xtal_dest;
	route_e trap_dest;
	route_e overtemp_dest;
	route_e irq7_src;
	route_e irq8_src;

	bus_decoder #(
		.MEM_WORDS(MEM_WORDS)
	) u_bus_decoder (
		.clk(clk),
		.resetn(resetn),
		.mem_valid(mem_valid),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_wstrb(mem_wstrb),
		.mem_ready(mem_ready),
		.mem_rdata(mem_rdata),
		.ram_wenb(ram_wenb),
		.ram_addr(ram_addr),
		.ram_wdata(ram_wdata),
		.ram_rdata(ram_rdata),
		.io_req(io_req),
		.io_ofs(io_ofs),
		.io_wdata(io_wdata),
		.io_wstrb(io_wstrb),
		.io_rdata(io_rdata)
	);

	io_regs u_io_regs (
		.clk(clk),
		.resetn(resetn),
		.io_req(io_req),
		.io_ofs(io_ofs),
		.io_wdata(io_wdata),
		.io_wstrb(io_wstrb),
		.io_rdata(io_rdata),
		.gpio_in(gpio_in),
		.gpio_out(gpio_out),
		.overtemp(overtemp),
		.gpio_reg(gpio_reg),
		.gpio_oeb_reg(gpio_oeb_reg),
		.gpio_pu_reg(gpio_pu_reg),
		.gpio_pd_reg(gpio_pd_reg),
		.comp_dest(comp_dest),
		.rcosc_dest(rcosc_dest),
		.xtal_dest(xtal_dest),
		.trap_dest(trap_dest),
		.overtemp_dest(overtemp_dest),
		.irq7_src(irq7_src),
		.irq8_src(irq8_src)
	);

	pin_router u_pin_router (
		.gpio_reg(gpio_reg),
		.gpio_oeb_reg(gpio_oeb_reg),
		.gpio_pu_reg(gpio_pu_reg),
		.gpio_pd_reg(gpio_pd_reg),
		.comp_dest(comp_dest),
		.rcosc_dest(rcosc_dest),
		.xtal_dest(xtal_dest),
		.trap_dest(trap_dest),
		.overtemp_dest(overtemp_dest),
		.comp_in(comp_in),
		.rcosc_in(rcosc_in),
		.xtal_in(xtal_in),
		.trap_in(trap_in),
		.overtemp(overtemp),
		.gpio_out(gpio_out),
		.gpio_outenb(gpio_outenb),
		.gpio_pullup(gpio_pullup),
		.gpio_pulldown(gpio_pulldown)
	);

	irq_router u_irq_router (
		.gpio_in(gpio_in),
		.irq7_src(irq7_src),
		.irq8_src(irq8_src),
		.comp_dest(comp_dest),
		.overtemp_dest(overtemp_dest),
		.comp_in(comp_in),
		.overtemp(overtemp),
		.irq_pin(irq_pin),
		.irq_spi(irq_spi),
		.irq(irq)
	);

endmodule

`default_nettype wire

//--- tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker import soc_pkg::*; #(
	parameter int MEM_WORDS = 1024
) (
	input wire clk,
	input wire resetn,
	// Bus as seen by the DUT
	input wire mem_valid,
	input wire [DATA_W-1:0] mem_addr,
	input wire [DATA_W-1:0] mem_wdata,
	input wire [STRB_W-1:0] mem_wstrb,
	input wire mem_ready,
	input wire [DATA_W-1:0] mem_rdata,
	// SRAM pins
	input wire ram_wenb,
	input wire [$clog2(MEM_WORDS)-1:0] ram_addr,
	input wire [DATA_W-1:0] ram_wdata,
	// Pads and sideband
	input wire [GPIO_W-1:0] gpio_in,
	input wire [GPIO_W-1:0] gpio_out,
	input wire [GPIO_W-1:0] gpio_outenb,
	input wire [GPIO_W-1:0] gpio_pullup,
	input wire [GPIO_W-1:0] gpio_pulldown,
	input wire comp_in,
	input wire rcosc_in,
	input wire xtal_in,
	input wire trap_in,
	input wire overtemp,
	input wire irq_pin,
	input wire irq_spi,
	input wire [IRQ_W-1:0] irq,
	output int err_count
);
	localparam int RAM_AW = $clog2(MEM_WORDS);

	int errors = 0;
	// Shadow of the register block
	logic [GPIO_W-1:0] gpio_sh;
	logic [GPIO_W-1:0] oeb_sh;
	logic [GPIO_W-1:0] pu_sh;
	logic [GPIO_W-1:0] pd_sh;
	logic [1:0] comp_sh;
	logic [1:0] rcosc_sh;
	logic [1:0] xtal_sh;
	logic [1:0] trap_sh;
	logic [1:0] ot_sh;
	logic [1:0] irq7_sh;
	logic [1:0] irq8_sh;
	// Only words written so far
	logic [DATA_W-1:0] ram_sh [int];
	// Access in flight
	logic ack_due;
	logic chk_read;
	logic [DATA_W-1:0] exp_rdata;

	assign err_count = errors;

	task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (act !== exp) begin
			$display("[FAIL] %0d ns %s expected %0h actual %0h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic protocol_error(input string what);
		$display("Handshake error at %0d ns: %s", $time, what);
		errors++;
	endtask

	task automatic reset_shadow();
		gpio_sh = '0;
		oeb_sh = '1;
		pu_sh = '0;
		pd_sh = '0;
		comp_sh = 2'd0;
		rcosc_sh = 2'd0;
		xtal_sh = 2'd0;
		trap_sh = 2'd0;
		ot_sh = 2'd0;
		irq7_sh = 2'd0;
		irq8_sh = 2'd0;
	endtask

	// Byte lanes 0 and 1 of a 16-bit register
	function automatic logic [15:0] lane_merge(input logic [15:0] cur, input logic [31:0] wd,
		input logic [3:0] st);
		logic [15:0] r;
		r = cur;
		for (int b = 0; b < 2; b++) begin
			if (st[b]) begin
				r[b*8 +: 8] = wd[b*8 +: 8];
			end
		end
		return r;
	endfunction

	function automatic logic [1:0] sel_merge(input logic [1:0] cur, input logic [31:0] wd,
		input logic [3:0] st);
		return st[0] ? wd[1:0] : cur;
	endfunction

	task automatic apply_write(input logic [7:0] ofs, input logic [31:0] wd, input logic [3:0] st);
		case (ofs)
			GPIO_DATA: gpio_sh = lane_merge(gpio_sh, wd, st);
			GPIO_OEB: oeb_sh = lane_merge(oeb_sh, wd, st);
			GPIO_PU: pu_sh = lane_merge(pu_sh, wd, st);
			GPIO_PD: pd_sh = lane_merge(pd_sh, wd, st);
			COMP_DEST: comp_sh = sel_merge(comp_sh, wd, st);
			RCOSC_DEST: rcosc_sh = sel_merge(rcosc_sh, wd, st);
			XTAL_DEST: xtal_sh = sel_merge(xtal_sh, wd, st);
			TRAP_DEST: trap_sh = sel_merge(trap_sh, wd, st);
			IRQ7_SRC: irq7_sh = sel_merge(irq7_sh, wd, st);
			IRQ8_SRC: irq8_sh = sel_merge(irq8_sh, wd, st);
			OVERTEMP_DEST: ot_sh = sel_merge(ot_sh, wd, st);
			default: ;
		endcase
	endtask

	// Expected read word with gout taken as the pad output before the access
	function automatic logic [31:0] io_read_ref(input logic [7:0] ofs, input logic [15:0] gout);
		case (ofs)
			GPIO_DATA: return {gout, gpio_in};
			GPIO_OEB: return {16'h0, oeb_sh};
			GPIO_PU: return {16'h0, pu_sh};
			GPIO_PD: return {16'h0, pd_sh};
			COMP_DEST: return {30'h0, comp_sh};
			RCOSC_DEST: return {30'h0, rcosc_sh};
			XTAL_DEST: return {30'h0, xtal_sh};
			TRAP_DEST: return {30'h0, trap_sh};
			IRQ7_SRC: return {30'h0, irq7_sh};
			IRQ8_SRC: return {30'h0, irq8_sh};
			OVERTEMP_STAT: return {31'h0, overtemp};
			OVERTEMP_DEST: return {30'h0, ot_sh};
			default: return 32'h0;
		endcase
	endfunction

	// Selector, lowest pin and signal of the group a pin belongs to
	function automatic void group_of(input int pin, output logic [1:0] sel, output int first,
		output logic sig);
		sel = 2'd0;
		first = pin;
		sig = 1'b0;
		if (pin <= 1) begin
			sel = comp_sh;
			first = 0;
			sig = comp_in;
		end else if (pin <= 4) begin
			sel = rcosc_sh;
			first = 2;
			sig = rcosc_in;
		end else if (pin <= 7) begin
			sel = xtal_sh;
			first = 5;
			sig = xtal_in;
		end else if (pin >= 11 && pin <= 13) begin
			sel = trap_sh;
			first = 11;
			sig = trap_in;
		end else if (pin >= 14) begin
			sel = ot_sh;
			first = 14;
			sig = overtemp;
		end
	endfunction

	// Packed as out, outenb, pullup, pulldown
	function automatic logic [63:0] pads_ref();
		logic [15:0] o;
		logic [15:0] e;
		logic [15:0] u;
		logic [15:0] d;
		logic [1:0] sel;
		int first;
		logic sig;
		o = gpio_sh;
		e = oeb_sh;
		u = pu_sh;
		d = pd_sh;
		for (int p = 0; p < GPIO_W; p++) begin
			group_of(p, sel, first, sig);
			if (sel != 2'd0) begin
				e[p] = 1'b0;
				u[p] = 1'b0;
				d[p] = 1'b0;
				// A drives the lowest pin, C the third
				if (p - first + 1 == int'(sel)) begin
					o[p] = sig;
				end
			end
		end
		return {o, e, u, d};
	endfunction

	function automatic logic [31:0] irq_ref();
		logic [31:0] v;
		v = '0;
		v[5] = irq_pin;
		v[6] = irq_spi;
		if (irq7_sh != 2'd0) begin
			v[7] = gpio_in[int'(irq7_sh) - 1];
		end
		if (irq8_sh != 2'd0) begin
			v[8] = gpio_in[int'(irq8_sh) + 2];
		end
		v[9] = comp_in && comp_sh == ROUTE_C;
		v[10] = overtemp && ot_sh == ROUTE_C;
		return v;
	endfunction

	// First cycle of an access
	task automatic start_access();
		logic in_ram;
		logic in_io;
		logic wr;
		int word;
		logic [63:0] pads_now;
		in_ram = mem_addr < 32'(4 * MEM_WORDS);
		in_io = mem_addr[31:8] == IO_PAGE;
		wr = |mem_wstrb;
		word = int'(mem_addr[RAM_AW+1:2]);
		chk_read = !wr;
		exp_rdata = '0;
		check_value("ram_wenb", 64'(!(in_ram && wr)), 64'(ram_wenb));
		if (in_ram) begin
			check_value("ram_addr", 64'(mem_addr[RAM_AW+1:2]), 64'(ram_addr));
			if (wr) begin
				// Whole word, strobes ignored by the SRAM
				check_value("ram_wdata", 64'(mem_wdata), 64'(ram_wdata));
				ram_sh[word] = mem_wdata;
			end else if (ram_sh.exists(word)) begin
				exp_rdata = ram_sh[word];
			end else begin
				chk_read = 1'b0;
			end
		end else if (in_io) begin
			pads_now = pads_ref();
			exp_rdata = io_read_ref(mem_addr[7:0], pads_now[63:48]);
			if (wr) begin
				apply_write(mem_addr[7:0], mem_wdata, mem_wstrb);
			end
		end
	endtask

	always @(posedge clk) begin
		logic [63:0] pads;
		if (!resetn) begin
			reset_shadow();
			ack_due = 1'b0;
		end else begin
			// Routed pads and interrupts every cycle
			pads = pads_ref();
			check_value("gpio_out", 64'(pads[63:48]), 64'(gpio_out));
			check_value("gpio_outenb", 64'(pads[47:32]), 64'(gpio_outenb));
			check_value("gpio_pullup", 64'(pads[31:16]), 64'(gpio_pullup));
			check_value("gpio_pulldown", 64'(pads[15:0]), 64'(gpio_pulldown));
			check_value("irq", 64'(irq_ref()), 64'(irq));
			if (ack_due) begin
				if (!mem_ready) begin
					protocol_error("mem_ready did not rise one cycle after the request");
				end else if (chk_read) begin
					check_value("mem_rdata", 64'(exp_rdata), 64'(mem_rdata));
				end
				// Write pulse belongs to the request cycle only
				if (!ram_wenb) begin
					protocol_error("ram_wenb low in the acknowledge cycle");
				end
				ack_due = 1'b0;
			end else begin
				if (mem_ready) begin
					protocol_error("mem_ready high with no access waiting for it");
				end
				if (mem_valid) begin
					start_access();
					ack_due = 1'b1;
				end else if (!ram_wenb) begin
					protocol_error("ram_wenb low with no access on the bus");
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top import soc_pkg::*; ();
	localparam int MEM_WORDS = 1024;
	localparam int RAM_AW = $clog2(MEM_WORDS);

	// Access counts per phase
	localparam int N_REGS = 12;
	localparam int N_RAM = 32;
	localparam int N_REG = 48;
	localparam int N_ROUTE = 12;
	localparam int N_UNMAPPED = 16;
	localparam int N_BAD_OFS = 8;
	localparam int PLANNED = N_REGS + 2 * N_RAM + 2 * N_REG + 8 * N_ROUTE + N_UNMAPPED
		+ 2 * N_BAD_OFS + N_REGS + N_RAM;
	localparam int TIMEOUT = 4 * PLANNED + 100;

	// Selectors at indices 4 to 10 and status last
	localparam logic [7:0] REG_OFS [N_REGS] = '{GPIO_DATA, GPIO_OEB, GPIO_PU, GPIO_PD,
		COMP_DEST, RCOSC_DEST, XTAL_DEST, TRAP_DEST, IRQ7_SRC, IRQ8_SRC, OVERTEMP_DEST,
		OVERTEMP_STAT};

	logic clk = 1'b0;
	logic resetn;
	logic mem_valid;
	logic [DATA_W-1:0] mem_addr;
	logic [DATA_W-1:0] mem_wdata;
	logic [STRB_W-1:0] mem_wstrb;
	logic mem_ready;
	logic [DATA_W-1:0] mem_rdata;
	logic ram_wenb;
	logic [RAM_AW-1:0] ram_addr;
	logic [DATA_W-1:0] ram_wdata;
	logic [DATA_W-1:0] ram_rdata = '0;
	logic [GPIO_W-1:0] gpio_in;
	logic [GPIO_W-1:0] gpio_out;
	logic [GPIO_W-1:0] gpio_outenb;
	logic [GPIO_W-1:0] gpio_pullup;
	logic [GPIO_W-1:0] gpio_pulldown;
	logic comp_in;
	logic rcosc_in;
	logic xtal_in;
	logic trap_in;
	logic overtemp;
	logic irq_pin;
	logic irq_spi;
	logic [IRQ_W-1:0] irq;
	int err_count;
	int cycles = 0;
	int n_acc = 0;
	int ram_words[$];
	// External synchronous SRAM
	logic [DATA_W-1:0] sram [MEM_WORDS];

	always #2 clk = ~clk;

	always @(posedge clk) begin
		if (!ram_wenb) begin
			sram[ram_addr] <= ram_wdata;
		end
		ram_rdata <= sram[ram_addr];
	end

	soc_bus_top #(
		.MEM_WORDS(MEM_WORDS)
	) u_dut (
		.clk(clk), .resetn(resetn),
		.mem_valid(mem_valid), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_wstrb(mem_wstrb), .mem_ready(mem_ready), .mem_rdata(mem_rdata),
		.ram_wenb(ram_wenb), .ram_addr(ram_addr), .ram_wdata(ram_wdata),
		.ram_rdata(ram_rdata), .gpio_in(gpio_in), .gpio_out(gpio_out),
		.gpio_outenb(gpio_outenb), .gpio_pullup(gpio_pullup), .gpio_pulldown(gpio_pulldown),
		.comp_in(comp_in), .rcosc_in(rcosc_in), .xtal_in(xtal_in), .trap_in(trap_in),
		.overtemp(overtemp), .irq_pin(irq_pin), .irq_spi(irq_spi), .irq(irq)
	);

	tb_checker #(
		.MEM_WORDS(MEM_WORDS)
	) u_checker (
		.clk(clk), .resetn(resetn),
		.mem_valid(mem_valid), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_wstrb(mem_wstrb), .mem_ready(mem_ready), .mem_rdata(mem_rdata),
		.ram_wenb(ram_wenb), .ram_addr(ram_addr), .ram_wdata(ram_wdata),
		.gpio_in(gpio_in), .gpio_out(gpio_out), .gpio_outenb(gpio_outenb),
		.gpio_pullup(gpio_pullup), .gpio_pulldown(gpio_pulldown),
		.comp_in(comp_in), .rcosc_in(rcosc_in), .xtal_in(xtal_in), .trap_in(trap_in),
		.overtemp(overtemp), .irq_pin(irq_pin), .irq_spi(irq_spi), .irq(irq),
		.err_count(err_count)
	);

	function automatic logic [31:0] io_addr(input logic [7:0] ofs);
		return {IO_PAGE, ofs};
	endfunction

	function automatic logic is_assigned(input logic [7:0] ofs);
		for (int i = 0; i < N_REGS; i++) begin
			if (REG_OFS[i] == ofs) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	// Word-aligned offset no register answers to
	function automatic logic [7:0] free_offset();
		logic [7:0] o;
		do begin
			o = 8'($urandom) & 8'hfc;
		end while (is_assigned(o));
		return o;
	endfunction

	// Above the SRAM window and off the I/O page
	function automatic logic [31:0] unmapped_addr();
		logic [31:0] a;
		a = $urandom | 32'h0001_0000;
		if (a[31:8] == IO_PAGE) begin
			a[31] = 1'b1;
		end
		return {a[31:2], 2'b00};
	endfunction

	task automatic drive_sideband();
		gpio_in = 16'($urandom);
		{comp_in, rcosc_in, xtal_in, trap_in, overtemp, irq_pin, irq_spi} = 7'($urandom);
	endtask

	// Starts 1 ns after an edge and returns 1 ns after the ack edge
	task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
		input logic [3:0] wstrb);
		mem_valid = 1'b1;
		mem_addr = addr;
		mem_wdata = wdata;
		mem_wstrb = wstrb;
		do begin
			@(posedge clk);
		end while (!mem_ready);
		#1;
		mem_valid = 1'b0;
		mem_wstrb = '0;
		n_acc++;
	endtask

	// Hang guard
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("Timeout: run still busy after %0d cycles", cycles);
			$display("TESTS FAILED");
			$finish;
		end
	end

	initial begin
		logic [7:0] ofs;
		int w;
		void'($urandom(17));
		resetn = 1'b0;
		mem_valid = 1'b0;
		mem_addr = '0;
		mem_wdata = '0;
		mem_wstrb = '0;
		gpio_in = '0;
		{comp_in, rcosc_in, xtal_in, trap_in, overtemp, irq_pin, irq_spi} = '0;
		repeat (2) @(posedge clk);
		#1;
		resetn = 1'b1;
		// Reset values of every register
		for (int i = 0; i < N_REGS; i++) begin
			bus_access(io_addr(REG_OFS[i]), 32'h0, 4'h0);
		end
		// SRAM writes followed by reads of the same words
		for (int i = 0; i < N_RAM; i++) begin
			w = int'($urandom_range(MEM_WORDS - 1, 0));
			ram_words.push_back(w);
			bus_access(32'(w * 4), $urandom, 4'($urandom_range(15, 1)));
		end
		foreach (ram_words[i]) begin
			bus_access(32'(ram_words[i] * 4), $urandom, 4'h0);
		end
		// Every register in turn gets random writes with a read back of each
		for (int i = 0; i < N_REG; i++) begin
			ofs = REG_OFS[i % N_REGS];
			drive_sideband();
			bus_access(io_addr(ofs), $urandom, 4'($urandom));
			bus_access(io_addr(ofs), 32'h0, 4'h0);
		end
		// New selectors followed by a few cycles of moving sideband inputs
		for (int r = 0; r < N_ROUTE; r++) begin
			for (int k = 4; k < 11; k++) begin
				bus_access(io_addr(REG_OFS[k]), $urandom, 4'h1);
			end
			repeat (3) begin
				drive_sideband();
				@(posedge clk);
				#1;
			end
			bus_access(io_addr(GPIO_DATA), 32'h0, 4'h0);
		end
		// Alternate writes and reads off the map
		for (int i = 0; i < N_UNMAPPED; i++) begin
			bus_access(unmapped_addr(), $urandom,
				(i % 2 == 0) ? 4'($urandom_range(15, 1)) : 4'h0);
		end
		for (int i = 0; i < N_BAD_OFS; i++) begin
			ofs = free_offset();
			bus_access(io_addr(ofs), $urandom, 4'hf);
			bus_access(io_addr(ofs), 32'h0, 4'h0);
		end
		// Nothing above may have disturbed registers or SRAM
		for (int i = 0; i < N_REGS; i++) begin
			bus_access(io_addr(REG_OFS[i]), 32'h0, 4'h0);
		end
		foreach (ram_words[i]) begin
			bus_access(32'(ram_words[i] * 4), 32'h0, 4'h0);
		end
		repeat (3) @(posedge clk);
		#1;
		$display("Run complete: %0d accesses, %0d errors", n_acc, err_count);
		if (err_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
soc_pkg.sv
bus_decoder.sv
io_regs.sv
pin_router.sv
irq_router.sv
soc_bus_top.sv
tb_checker.sv
tb_top.sv

//--- Makefile
# Verilator build and run for the SoC bus testbench

SIM ?= verilator
TOP ?= tb_top
FILELIST ?= all.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
